//--- Bender.yml
package:
  name: cascade_phy

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cascade_pkg.sv
      - src/cascade_serdes.sv
      - src/cascade_trainer.sv
      - src/cascade_phy_master.sv

  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_channel.sv
      - tests/cascade_phy_props.sv
      - tests/tb_cascade_phy.sv

//--- src/cascade_params.svh
`ifndef CASCADE_PARAMS_SVH
`define CASCADE_PARAMS_SVH

// bits carried by one lane per word
`define CASCADE_SER_FACTOR 4

`define CASCADE_DAT_LANES 2
`define CASCADE_CMD_LANES 1
`define CASCADE_LANES (`CASCADE_DAT_LANES + `CASCADE_CMD_LANES)

// every rotation of this word is distinct, so a misaligned lane never matches
`define CASCADE_TRAIN_WORD 4'b0001

// lock and retry limits counted in words
`define CASCADE_LOCK_WORDS 4
`define CASCADE_SETTLE_WORDS 2
`define CASCADE_MAX_SLIPS 8

`endif

//--- src/cascade_phy_master.sv
`timescale 1ns/1ps
`default_nettype none

module cascade_phy_master
  import cascade_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_arst_n,

  // serial pins
  output lane_mask_t      o_tx_ser,
  input  wire lane_mask_t i_rx_ser,

  // user side
  input  wire phy_word_s  i_tx_word,
  output logic            o_word_stb,
  output phy_word_s       o_rx_word,
  output logic            o_rx_valid,

  // link control and status
  input  wire logic       i_hot_plug,
  input  wire logic       i_retrain,
  output logic            o_link_up,
  output logic            o_train_err,
  output lane_mask_t      o_lane_locked
);

  logic       word_stb;
  phy_word_s  rx_word;
  phy_word_s  tx_word;
  lane_mask_t slip;

  cascade_serdes u_serdes (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_tx_word  (tx_word),
    .i_slip     (slip),
    .i_rx_ser   (i_rx_ser),
    .o_tx_ser   (o_tx_ser),
    .o_word_stb (word_stb),
    .o_rx_word  (rx_word)
  );

  // the trainer owns the transmit mux and the receive valid
  cascade_trainer u_trainer (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_hot_plug    (i_hot_plug),
    .i_retrain     (i_retrain),
    .i_word_stb    (word_stb),
    .i_rx_word     (rx_word),
    .i_user_word   (i_tx_word),
    .o_tx_word     (tx_word),
    .o_slip        (slip),
    .o_rx_valid    (o_rx_valid),
    .o_lane_locked (o_lane_locked),
    .o_link_up     (o_link_up),
    .o_train_err   (o_train_err)
  );

  assign o_word_stb = word_stb;
  assign o_rx_word  = rx_word;

endmodule

`default_nettype wire

//--- src/cascade_pkg.sv
`default_nettype none

`include "cascade_params.svh"

package cascade_pkg;

  typedef logic [`CASCADE_SER_FACTOR-1:0] lane_word_t;

  // data lanes in the low bits, command lane in the top bit
  typedef logic [`CASCADE_LANES-1:0] lane_mask_t;

  typedef struct packed {
    lane_word_t [`CASCADE_DAT_LANES-1:0] dat;
    lane_word_t [`CASCADE_CMD_LANES-1:0] cmd;
  } phy_word_s;

  typedef enum logic [2:0] {
    IDLE,
    SEND,
    COMPARE,
    SLIP,
    SETTLE,
    LINKED,
    FAIL
  } train_state_e;

  // lane index follows the lane_mask_t bit order
  function automatic lane_word_t get_lane(phy_word_s w, int unsigned idx);
    if (idx < `CASCADE_DAT_LANES)
      return w.dat[idx];
    return w.cmd[idx - `CASCADE_DAT_LANES];
  endfunction

  function automatic phy_word_s set_lane(phy_word_s w, int unsigned idx, lane_word_t v);
    phy_word_s r;
    r = w;
    if (idx < `CASCADE_DAT_LANES)
      r.dat[idx] = v;
    else
      r.cmd[idx - `CASCADE_DAT_LANES] = v;
    return r;
  endfunction

endpackage

`default_nettype wire

//--- src/cascade_serdes.sv
`timescale 1ns/1ps
`default_nettype none

`include "cascade_params.svh"

module cascade_serdes
  import cascade_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_arst_n,
  input  wire phy_word_s  i_tx_word,
  input  wire lane_mask_t i_slip,
  input  wire lane_mask_t i_rx_ser,
  output lane_mask_t      o_tx_ser,
  output logic            o_word_stb,
  output phy_word_s       o_rx_word
);

  localparam int SF    = `CASCADE_SER_FACTOR;
  localparam int CNT_W = $clog2(SF);

  logic [CNT_W-1:0]                bit_cnt;
  lane_word_t [`CASCADE_LANES-1:0] rx_lane;
  phy_word_s                       rx_cap;

  // common word timing with the strobe on the last bit of every word
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      bit_cnt <= '0;
    else if (bit_cnt == CNT_W'(SF - 1))
      bit_cnt <= '0;
    else
      bit_cnt <= bit_cnt + 1'b1;
  end

  assign o_word_stb = (bit_cnt == CNT_W'(SF - 1));

  for (genvar l = 0; l < `CASCADE_LANES; l++)
  begin : g_lane
    lane_word_t       tx_shift;
    lane_word_t       rx_shift;
    lane_word_t       rx_hold;
    logic [CNT_W-1:0] bnd_cnt;

    // lsb leaves first in the cycle after the strobe
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
      if (!i_arst_n)
        tx_shift <= '0;
      else if (o_word_stb)
        tx_shift <= get_lane(i_tx_word, l);
      else
        tx_shift <= tx_shift >> 1;
    end

    assign o_tx_ser[l] = tx_shift[0];

    // a slip holds the counter once and pushes this lane's boundary one bit later
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
      if (!i_arst_n)
        bnd_cnt <= '0;
      else if (!i_slip[l])
      begin
        if (bnd_cnt == CNT_W'(SF - 1))
          bnd_cnt <= '0;
        else
          bnd_cnt <= bnd_cnt + 1'b1;
      end
    end

    always_ff @(posedge i_clk)
    begin
      rx_shift <= {i_rx_ser[l], rx_shift[SF-1:1]};
      if (bnd_cnt == CNT_W'(SF - 1))
        rx_hold <= {i_rx_ser[l], rx_shift[SF-1:1]};
    end

    assign rx_lane[l] = rx_hold;
  end

  always_comb
  begin
    rx_cap = '0;
    for (int l = 0; l < `CASCADE_LANES; l++)
      rx_cap = set_lane(rx_cap, l, rx_lane[l]);
  end

  // lanes capture on their own phase and are handed over together on the strobe
  always_ff @(posedge i_clk)
  begin
    if (o_word_stb)
      o_rx_word <= rx_cap;
  end

endmodule

`default_nettype wire

//--- src/cascade_trainer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cascade_params.svh"

module cascade_trainer
  import cascade_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_arst_n,
  input  wire logic       i_hot_plug,
  input  wire logic       i_retrain,
  input  wire logic       i_word_stb,
  input  wire phy_word_s  i_rx_word,
  input  wire phy_word_s  i_user_word,
  output phy_word_s       o_tx_word,
  output lane_mask_t      o_slip,
  output logic            o_rx_valid,
  output lane_mask_t      o_lane_locked,
  output logic            o_link_up,
  output logic            o_train_err
);

  localparam int LOCK_W = $clog2(`CASCADE_LOCK_WORDS + 1);
  localparam int SLIP_W = $clog2(`CASCADE_MAX_SLIPS + 1);

  // lets the idle zeros drain out of the loop before the first compare
  localparam int FILL_WORDS = `CASCADE_LOCK_WORDS;
  localparam int WAIT_MAX   = (FILL_WORDS > `CASCADE_SETTLE_WORDS) ?
                              FILL_WORDS : `CASCADE_SETTLE_WORDS;
  localparam int WAIT_W     = $clog2(WAIT_MAX + 1);

  localparam phy_word_s TRAIN_PHY = {`CASCADE_LANES{`CASCADE_TRAIN_WORD}};

  train_state_e      state;
  logic              hp_meta;
  logic              hp_sync;
  logic [WAIT_W-1:0] wait_cnt;
  logic [LOCK_W-1:0] match_cnt [`CASCADE_LANES];
  logic [SLIP_W-1:0] slip_cnt [`CASCADE_LANES];
  lane_mask_t        locked;
  lane_mask_t        slip_req;
  lane_mask_t        lock_next;
  lane_mask_t        mis_mask;
  logic              slip_over;
  logic              restart;

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      hp_meta <= 1'b0;
      hp_sync <= 1'b0;
    end
    else
    begin
      hp_meta <= i_hot_plug;
      hp_sync <= hp_meta;
    end
  end

  assign restart = !hp_sync || i_retrain;

  // per-lane verdict for the current receive word
  always_comb
  begin
    lock_next = locked;
    mis_mask  = '0;
    slip_over = 1'b0;
    for (int l = 0; l < `CASCADE_LANES; l++)
    begin
      if (!locked[l])
      begin
        if (get_lane(i_rx_word, l) == `CASCADE_TRAIN_WORD)
        begin
          if (match_cnt[l] == LOCK_W'(`CASCADE_LOCK_WORDS - 1))
            lock_next[l] = 1'b1;
        end
        else
        begin
          mis_mask[l] = 1'b1;
          if (slip_cnt[l] == SLIP_W'(`CASCADE_MAX_SLIPS))
            slip_over = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state    <= IDLE;
      wait_cnt <= '0;
      locked   <= '0;
      slip_req <= '0;
      for (int l = 0; l < `CASCADE_LANES; l++)
      begin
        match_cnt[l] <= '0;
        slip_cnt[l]  <= '0;
      end
    end
    else if (restart)
    begin
      // retrain goes straight back to sending, unplug waits in idle
      state    <= hp_sync ? SEND : IDLE;
      wait_cnt <= '0;
      locked   <= '0;
      slip_req <= '0;
      for (int l = 0; l < `CASCADE_LANES; l++)
      begin
        match_cnt[l] <= '0;
        slip_cnt[l]  <= '0;
      end
    end
    else if (i_word_stb)
    begin
      case (state)
        IDLE:
        begin
          state    <= SEND;
          wait_cnt <= '0;
        end
        SEND:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == WAIT_W'(FILL_WORDS - 1))
            state <= COMPARE;
        end
        COMPARE:
        begin
          for (int l = 0; l < `CASCADE_LANES; l++)
          begin
            if (mis_mask[l])
            begin
              match_cnt[l] <= '0;
              slip_cnt[l]  <= slip_cnt[l] + 1'b1;
            end
            else if (!locked[l])
              match_cnt[l] <= match_cnt[l] + 1'b1;
          end
          locked   <= lock_next;
          slip_req <= mis_mask;
          if (slip_over)
            state <= FAIL;
          else if (mis_mask != '0)
            state <= SLIP;
          else if (&lock_next)
            state <= LINKED;
        end
        SLIP:
        begin
          state    <= SETTLE;
          wait_cnt <= '0;
        end
        SETTLE:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == WAIT_W'(`CASCADE_SETTLE_WORDS - 1))
            state <= COMPARE;
        end
        default:
          state <= state;
      endcase
    end
  end

  // slip pulses go out on the strobe itself
  assign o_slip = (state == SLIP && i_word_stb) ? slip_req : '0;

  always_comb
  begin
    case (state)
      IDLE:    o_tx_word = '0;
      LINKED:  o_tx_word = i_user_word;
      default: o_tx_word = TRAIN_PHY;
    endcase
  end

  assign o_rx_valid    = (state == LINKED) && i_word_stb;
  assign o_link_up     = (state == LINKED);
  assign o_train_err   = (state == FAIL);
  assign o_lane_locked = locked;

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/cascade_pkg.sv
src/cascade_serdes.sv
src/cascade_trainer.sv
src/cascade_phy_master.sv
tests/tb_clk_gen.sv
tests/tb_channel.sv
tests/cascade_phy_props.sv
tests/tb_cascade_phy.sv

//--- tests/cascade_phy_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "cascade_params.svh"

module cascade_phy_props
  import cascade_pkg::*;
(
  input wire logic       i_clk,
  input wire logic       i_arst_n,
  input wire logic       i_word_stb,
  input wire logic       i_rx_valid,
  input wire logic       i_link_up,
  input wire logic       i_train_err,
  input wire lane_mask_t i_lane_locked,
  input wire lane_mask_t i_slip
);

  int unsigned fail_cnt = 0;

  a_valid_on_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(i_rx_valid) |-> i_word_stb)
    else
    begin
      fail_cnt++;
      $error("o_rx_valid rose without the word strobe");
    end

  a_link_locked: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_link_up |-> &i_lane_locked)
    else
    begin
      fail_cnt++;
      $error("o_link_up high while a lane is unlocked");
    end

  a_link_xor_err: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_link_up && i_train_err))
    else
    begin
      fail_cnt++;
      $error("o_link_up and o_train_err high together");
    end

  // slips are single strobe-cycle pulses
  a_slip_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (|i_slip) |=> (i_slip == '0))
    else
    begin
      fail_cnt++;
      $error("slip pulse longer than one cycle");
    end

endmodule

bind cascade_phy_master cascade_phy_props u_props (
  .i_clk         (i_clk),
  .i_arst_n      (i_arst_n),
  .i_word_stb    (o_word_stb),
  .i_rx_valid    (o_rx_valid),
  .i_link_up     (o_link_up),
  .i_train_err   (o_train_err),
  .i_lane_locked (o_lane_locked),
  .i_slip        (slip)
);

`default_nettype wire

//--- tests/tb_cascade_phy.sv
`timescale 1ns/1ps
`default_nettype none

`include "cascade_params.svh"

module tb_cascade_phy
  import cascade_pkg::*;
();

  localparam int L            = `CASCADE_LANES;
  localparam int LINK_TIMEOUT = 3000;
  localparam int MAX_SKIP     = 8;

  logic              clk;
  logic              arst_n;
  lane_mask_t        tx_ser;
  lane_mask_t        rx_ser;
  lane_mask_t        lane_locked;
  lane_mask_t        stuck;
  phy_word_s         tx_word;
  phy_word_s         rx_word;
  logic              word_stb;
  logic              rx_valid;
  logic              hot_plug;
  logic              retrain;
  logic              link_up;
  logic              train_err;
  logic [L-1:0][2:0] delay;
  int                mismatches = 0;
  int                failures = 0;

  tb_clk_gen u_clk_gen (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  cascade_phy_master u_cascade_phy_master (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .o_tx_ser      (tx_ser),
    .i_rx_ser      (rx_ser),
    .i_tx_word     (tx_word),
    .o_word_stb    (word_stb),
    .o_rx_word     (rx_word),
    .o_rx_valid    (rx_valid),
    .i_hot_plug    (hot_plug),
    .i_retrain     (retrain),
    .o_link_up     (link_up),
    .o_train_err   (train_err),
    .o_lane_locked (lane_locked)
  );

  tb_channel u_channel (
    .i_clk   (clk),
    .i_tx    (tx_ser),
    .i_delay (delay),
    .i_stuck (stuck),
    .o_rx    (rx_ser)
  );

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_val(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      mismatches++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, exp, act);
    end
  endtask

  task automatic wait_status(input string test, input logic want_link, input logic want_err);
    int n;
    n = 0;
    while ((link_up !== want_link || train_err !== want_err) && n < LINK_TIMEOUT)
    begin
      step();
      n++;
    end
    if (link_up !== want_link || train_err !== want_err)
    begin
      failures++;
      $display("%s: timed out waiting for link_up=%0b train_err=%0b",
               test, want_link, want_err);
    end
  endtask

  task automatic draw_delays(input string test);
    for (int l = 0; l < L; l++)
      delay[l] = 3'($urandom % 8);
    $display("%s: lane delays %h", test, delay);
  endtask

  task automatic pulse_retrain();
    retrain = 1'b1;
    step();
    retrain = 1'b0;
  endtask

  // lane order is data lanes first, command lane last
  function automatic phy_word_s join_lanes(input lane_word_t lanes [L]);
    phy_word_s w;
    for (int d = 0; d < `CASCADE_DAT_LANES; d++)
      w.dat[d] = lanes[d];
    for (int c = 0; c < `CASCADE_CMD_LANES; c++)
      w.cmd[c] = lanes[`CASCADE_DAT_LANES + c];
    return w;
  endfunction

  task automatic split_word(input phy_word_s w, output lane_word_t lanes [L]);
    for (int d = 0; d < `CASCADE_DAT_LANES; d++)
      lanes[d] = w.dat[d];
    for (int c = 0; c < `CASCADE_CMD_LANES; c++)
      lanes[`CASCADE_DAT_LANES + c] = w.cmd[c];
  endtask

  task automatic run_traffic(input string test, input int n_words);
    lane_word_t exp_q [L][$];
    lane_word_t got [L];
    lane_word_t nxt [L];
    lane_word_t exp;
    int         skipped [L];
    int         matched [L];
    int         sent;
    int         n;
    int         stb_gap;
    bit         seen_stb;
    bit         abort;
    bit         busy;
    sent     = 0;
    n        = 0;
    stb_gap  = 0;
    seen_stb = 1'b0;
    abort    = 1'b0;
    busy     = 1'b1;
    for (int l = 0; l < L; l++)
    begin
      skipped[l] = 0;
      matched[l] = 0;
    end
    while (busy && !abort && n < 8 * n_words + 200)
    begin
      step();
      n++;
      stb_gap++;
      if (!link_up)
      begin
        failures++;
        abort = 1'b1;
        $display("%s: link dropped during traffic", test);
      end
      if (rx_valid && !abort)
      begin
        split_word(rx_word, got);
        for (int l = 0; l < L; l++)
        begin
          // training words still in flight are dropped until the first sent word shows up
          if (matched[l] == 0 && (exp_q[l].size() == 0 || got[l] !== exp_q[l][0]))
          begin
            skipped[l]++;
            if (skipped[l] > MAX_SKIP)
            begin
              failures++;
              abort = 1'b1;
              $display("%s: lane %0d never delivered the first sent word", test, l);
            end
          end
          else if (exp_q[l].size() > 0)
          begin
            exp = exp_q[l].pop_front();
            matched[l]++;
            if (got[l] !== exp)
            begin
              mismatches++;
              $display("MISMATCH %s lane %0d word %0d: expected %h, actual %h",
                       test, l, matched[l] - 1, exp, got[l]);
            end
          end
        end
      end
      if (word_stb)
      begin
        if (seen_stb && stb_gap != `CASCADE_SER_FACTOR)
        begin
          mismatches++;
          $display("MISMATCH %s strobe spacing: expected %0d, actual %0d",
                   test, `CASCADE_SER_FACTOR, stb_gap);
        end
        seen_stb = 1'b1;
        stb_gap  = 0;
        for (int l = 0; l < L; l++)
        begin
          // user words never look like the training word
          do
            nxt[l] = lane_word_t'($urandom);
          while (nxt[l] == `CASCADE_TRAIN_WORD);
          if (sent < n_words)
            exp_q[l].push_back(nxt[l]);
        end
        tx_word = join_lanes(nxt);
        sent++;
      end
      busy = (sent < n_words);
      for (int l = 0; l < L; l++)
        if (exp_q[l].size() > 0)
          busy = 1'b1;
    end
    if (busy && !abort)
    begin
      failures++;
      $display("%s: timed out before all sent words came back", test);
    end
  endtask

  initial
  begin
    int n;
    int assert_fails;
    void'($urandom(32'h5d2a));
    tx_word  = '0;
    hot_plug = 1'b0;
    retrain  = 1'b0;
    stuck    = '0;
    delay    = '0;
    n = 0;
    while (arst_n !== 1'b1 && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    if (arst_n !== 1'b1)
    begin
      failures++;
      $display("reset was never released");
    end
    repeat (6) step();

    check_val("reset", "link_up", 0, link_up);
    check_val("reset", "train_err", 0, train_err);
    check_val("reset", "rx_valid", 0, rx_valid);
    check_val("reset", "lane_locked", 0, lane_locked);
    check_val("reset", "tx_ser", 0, tx_ser);

    draw_delays("training");
    hot_plug = 1'b1;
    wait_status("training", 1'b1, 1'b0);
    check_val("training", "lane_locked", (1 << L) - 1, lane_locked);

    run_traffic("traffic", 40);

    draw_delays("retrain");
    pulse_retrain();
    check_val("retrain", "link_up after pulse", 0, link_up);
    wait_status("retrain", 1'b1, 1'b0);
    run_traffic("retrain traffic", 40);

    stuck[$urandom % L] = 1'b1;
    pulse_retrain();
    wait_status("stuck lane", 1'b0, 1'b1);
    stuck    = '0;
    hot_plug = 1'b0;
    wait_status("unplug", 1'b0, 1'b0);
    hot_plug = 1'b1;
    wait_status("replug", 1'b1, 1'b0);
    run_traffic("replug traffic", 20);

    assert_fails = u_cascade_phy_master.u_props.fail_cnt;
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, assert_fails);
    if (mismatches == 0 && failures == 0 && assert_fails == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "cascade_params.svh"

module tb_channel
  import cascade_pkg::*;
(
  input  wire logic                           i_clk,
  input  wire lane_mask_t                     i_tx,
  input  wire logic [`CASCADE_LANES-1:0][2:0] i_delay,
  input  wire lane_mask_t                     i_stuck,
  output lane_mask_t                          o_rx
);

  // bit history per lane with the newest bit in position 0
  logic [7:0] hist [`CASCADE_LANES];

  always_ff @(posedge i_clk)
  begin
    for (int l = 0; l < `CASCADE_LANES; l++)
      hist[l] <= {hist[l][6:0], i_tx[l]};
  end

  always_comb
  begin
    for (int l = 0; l < `CASCADE_LANES; l++)
    begin
      if (i_stuck[l])
        o_rx[l] = 1'b0;
      else if (i_delay[l] == 3'd0)
        o_rx[l] = i_tx[l];
      else
        o_rx[l] = hist[l][i_delay[l] - 3'd1];
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_arst_n
);

  localparam real HALF_PERIOD = 5.0;
  localparam int  RST_CYCLES  = 2;

  initial
  begin
    o_clk = 1'b0;
    forever
    begin
      #(HALF_PERIOD);
      o_clk = ~o_clk;
    end
  end

  // release just after an edge so the DUT sees a clean deassert
  initial
  begin
    o_arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1;
    o_arst_n = 1'b1;
  end

endmodule

`default_nettype wire
